/* src.f */
hw/cpu_bus_pkg.sv
hw/fme7_pkg.sv
hw/fme7_regs.sv
hw/fme7_irq.sv
hw/fme7_addr_map.sv
hw/fme7_top.sv
testbench/fme7_tb.sv

/* Bender.yml */
package:
  name: fme7

sources:
  - hw/cpu_bus_pkg.sv
  - hw/fme7_pkg.sv
  - hw/fme7_regs.sv
  - hw/fme7_irq.sv
  - hw/fme7_addr_map.sv
  - hw/fme7_top.sv
  - target: simulation
    files:
      - testbench/fme7_tb.sv

/* testbench/fme7_tb.sv */
// FME-7 mapper testbench
module fme7_tb;

	localparam int CLK_PERIOD = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 8;
	localparam logic [31:0] LFSR_SEED = 32'h67bd_8574;
	localparam int IRQ_N = 37;          // Counter load value
	localparam int TOTAL_WRITES = 22;   // Register writes over all tests
	localparam int TOTAL_PROBES = 37;   // Output checks, one cycle each
	localparam int CYCLE_BUDGET = RESET_CYCLES + 2 * TOTAL_WRITES + TOTAL_PROBES + IRQ_N + 3;

	logic                               clk;
	logic                               rst_n;
	logic                               cpu_ce;
	cpu_bus_pkg::cpu_bus_t              cpu;
	cpu_bus_pkg::chr_bus_t              chr_ain;
	logic [cpu_bus_pkg::PRG_ADDR_W-1:0] prg_addr;
	logic                               prg_allow;
	logic [cpu_bus_pkg::CHR_ADDR_W-1:0] chr_addr;
	logic                               vram_a10;
	logic                               vram_ce;
	logic                               irq;

	logic [31:0] lfsr;
	int          errors;
	int          tests_passed;
	int          tests_failed;

	fme7_top uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_ce    (cpu_ce),
		.cpu       (cpu),
		.chr_ain   (chr_ain),
		.prg_addr  (prg_addr),
		.prg_allow (prg_allow),
		.chr_addr  (chr_addr),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce),
		.irq       (irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Command write to $8000, then parameter write to $A000
	task automatic write_reg(input logic [3:0] cmd, input logic [7:0] value);
		cpu.addr = 16'h8000;
		cpu.data = {4'h0, cmd};
		cpu.write = 1'b1;
		cpu.read = 1'b0;
		cycle();
		cpu.addr = 16'hA000;
		cpu.data = value;
		cycle();
		cpu.write = 1'b0;
	endtask

	task automatic check_prg(input logic [15:0] addr, input logic wr,
			input logic [21:0] exp_addr, input logic exp_allow, input string what);
		cycle();
		cpu.addr = addr;
		cpu.data = 8'h00;
		cpu.write = wr;
		cpu.read = !wr;
		#1;
		if (prg_addr !== exp_addr) begin
			$display("Fail %0t: %s prg_addr %h, expected %h", $time, what, prg_addr, exp_addr);
			errors++;
		end
		if (prg_allow !== exp_allow) begin
			$display("Fail %0t: %s prg_allow %b, expected %b", $time, what, prg_allow, exp_allow);
			errors++;
		end
	endtask

	task automatic check_chr(input logic [13:0] ain, input logic [21:0] exp_addr,
			input logic exp_ce);
		cycle();
		chr_ain = ain;
		#1;
		if (chr_addr !== exp_addr) begin
			$display("Fail %0t: chr_ain %h gives chr_addr %h, expected %h",
				$time, ain, chr_addr, exp_addr);
			errors++;
		end
		if (vram_ce !== exp_ce) begin
			$display("Fail %0t: chr_ain %h gives vram_ce %b", $time, ain, vram_ce);
			errors++;
		end
	endtask

	task automatic check_a10(input logic [13:0] ain, input logic exp_a10, input string what);
		cycle();
		chr_ain = ain;
		#1;
		if (vram_a10 !== exp_a10) begin
			$display("Fail %0t: %s chr_ain %h gives vram_a10 %b", $time, what, ain, vram_a10);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (errors == 0) tests_passed++;
		else tests_failed++;
		$display("%s: %0d errors", name, errors);
		errors = 0;
	endtask

	task automatic test_reset_state();
		cycle();
		if (irq !== 1'b0) begin
			$display("Fail %0t: irq high after reset", $time);
			errors++;
		end
		check_a10(14'h0400, 1'b1, "reset");
		check_a10(14'h0000, 1'b0, "reset");
		check_prg(16'h6000, 1'b0, 22'h0, 1'b1, "reset $6000");  // ROM bank 0
		finish_test("reset_state");
	endtask

	task automatic test_prg_banking();
		logic [31:0] r;
		logic [4:0]  banks [4];
		for (int w = 0; w < 4; w++) begin
			take_bits(5, r);
			banks[w] = r[4:0];
			write_reg(4'(fme7_pkg::CMD_PRG_FIRST + w), {3'b000, banks[w]});
		end
		for (int w = 0; w < 4; w++) begin
			take_bits(13, r);
			check_prg({3'(w + 3), r[12:0]}, 1'b0, {4'b0000, banks[w], r[12:0]}, 1'b1,
				"prg window");
		end
		take_bits(13, r);
		check_prg({3'b111, r[12:0]}, 1'b0, {4'b0000, 5'd31, r[12:0]}, 1'b1, "$E000");
		finish_test("prg_banking");
	endtask

	task automatic test_ram_gating();
		logic [31:0] r;
		logic [31:0] low;
		take_bits(5, r);
		take_bits(13, low);
		write_reg(fme7_pkg::CMD_PRG_FIRST, {3'b010, r[4:0]});  // Selected, disabled
		check_prg({3'b011, low[12:0]}, 1'b0, {2'b01, 2'b00, r[4:0], low[12:0]}, 1'b0,
			"ram disabled");
		write_reg(fme7_pkg::CMD_PRG_FIRST, {3'b110, r[4:0]});
		check_prg({3'b011, low[12:0]}, 1'b0, {2'b01, 2'b00, r[4:0], low[12:0]}, 1'b1,
			"ram read");
		check_prg({3'b011, low[12:0]}, 1'b1, {2'b01, 2'b00, r[4:0], low[12:0]}, 1'b1,
			"ram write");
		finish_test("ram_gating");
	endtask

	task automatic test_chr_banking();
		logic [31:0] r;
		logic [7:0]  banks [8];
		for (int k = 0; k < 8; k++) begin
			take_bits(8, r);
			banks[k] = r[7:0];
			write_reg(4'(k), banks[k]);
		end
		for (int k = 0; k < 8; k++) begin
			take_bits(10, r);
			check_chr({1'b0, 3'(k), r[9:0]}, {4'b1000, banks[k], r[9:0]}, 1'b0);
		end
		take_bits(10, r);
		check_chr({1'b1, 3'd5, r[9:0]}, {4'b1000, banks[5], r[9:0]}, 1'b1);  // Nametable area
		finish_test("chr_banking");
	endtask

	task automatic test_mirroring();
		logic expected;
		for (int m = 0; m < 4; m++) begin
			write_reg(fme7_pkg::CMD_MIRROR, 8'(m));
			for (int c = 0; c < 4; c++) begin
				case (m)
					0: expected = c[0];    // Vertical
					1: expected = c[1];    // Horizontal
					2: expected = 1'b0;
					default: expected = 1'b1;
				endcase
				check_a10({2'b10, 2'(c), 10'h155}, expected, "mirroring");
			end
		end
		finish_test("mirroring");
	endtask

	task automatic test_irq();
		int edges;
		write_reg(fme7_pkg::CMD_IRQ_LO, 8'(IRQ_N));
		write_reg(fme7_pkg::CMD_IRQ_HI, 8'(IRQ_N >> 8));
		write_reg(fme7_pkg::CMD_IRQ_CTRL, 8'h81);  // Countdown and trigger
		for (int i = 1; i <= IRQ_N; i++) begin
			cycle();
			if (irq !== 1'b0) begin
				$display("Fail %0t: irq high after %0d counted edges", $time, i);
				errors++;
			end
		end
		cycle();
		if (irq !== 1'b1) begin
			$display("Fail %0t: irq low after %0d counted edges", $time, IRQ_N + 1);
			errors++;
		end
		write_reg(fme7_pkg::CMD_IRQ_CTRL, 8'h00);
		edges = 1;                                 // Control write edge itself
		while (irq !== 1'b0 && edges < 2) begin
			cycle();
			edges++;
		end
		if (irq !== 1'b0) begin
			$display("Fail %0t: irq still high two edges after trigger cleared", $time);
			errors++;
		end
		finish_test("irq");
	endtask

	initial begin
		rst_n = 1'b0;
		cpu_ce = 1'b1;
		cpu = '0;
		chr_ain = '0;
		lfsr = LFSR_SEED;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		test_reset_state();
		test_prg_banking();
		test_ram_gating();
		test_chr_banking();
		test_mirroring();
		test_irq();

		$display("Tests passed: %0d, tests with errors: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(4 * CYCLE_BUDGET * CLK_PERIOD);
		$display("Watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

/* hw/fme7_top.sv */
// Sunsoft FME-7 mapper
module fme7_top (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               cpu_ce,
	input  cpu_bus_pkg::cpu_bus_t              cpu,
	input  cpu_bus_pkg::chr_bus_t              chr_ain,
	output logic [cpu_bus_pkg::PRG_ADDR_W-1:0] prg_addr,
	output logic                               prg_allow,
	output logic [cpu_bus_pkg::CHR_ADDR_W-1:0] chr_addr,
	output logic                               vram_a10,
	output logic                               vram_ce,
	output logic                               irq
);

	fme7_pkg::bank_state_t bank;   // Current banking state
	fme7_pkg::irq_wr_t     irq_wr; // Counter and control loads

	fme7_regs u_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.cpu_ce (cpu_ce),
		.cpu    (cpu),
		.bank   (bank),
		.irq_wr (irq_wr)
	);

	fme7_irq u_irq (
		.clk    (clk),
		.rst_n  (rst_n),
		.cpu_ce (cpu_ce),
		.irq_wr (irq_wr),
		.irq    (irq)
	);

	fme7_addr_map u_addr_map (
		.cpu       (cpu),
		.chr_ain   (chr_ain),
		.bank      (bank),
		.prg_addr  (prg_addr),
		.prg_allow (prg_allow),
		.chr_addr  (chr_addr),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce)
	);

endmodule

/* hw/fme7_addr_map.sv */
// FME-7 address translation
module fme7_addr_map (
	input  cpu_bus_pkg::cpu_bus_t                cpu,
	input  cpu_bus_pkg::chr_bus_t                chr_ain,
	input  fme7_pkg::bank_state_t                bank,
	output logic [cpu_bus_pkg::PRG_ADDR_W-1:0]   prg_addr,
	output logic                                 prg_allow,
	output logic [cpu_bus_pkg::CHR_ADDR_W-1:0]   chr_addr,
	output logic                                 vram_a10,
	output logic                                 vram_ce
);

	logic                ram_cs;  // Work RAM chip select
	fme7_pkg::prg_bank_t prg_sel;
	fme7_pkg::chr_bank_t chr_sel;

	// 8 kB PRG windows
	always_comb begin
		case (cpu.addr[15:13])
			3'b011: prg_sel = bank.prg[0]; // $6000
			3'b100: prg_sel = bank.prg[1]; // $8000
			3'b101: prg_sel = bank.prg[2]; // $A000
			3'b110: prg_sel = bank.prg[3]; // $C000
			3'b111: prg_sel = '1;          // $E000 fixed to last bank
			default: prg_sel = '0;
		endcase
	end

	assign ram_cs = !cpu.addr[15] && bank.ram_select;
	assign prg_addr = {1'b0, ram_cs, 2'b00, prg_sel, cpu.addr[12:0]};

	// ROM is read only, RAM follows its enable
	assign prg_allow = ram_cs ? bank.ram_enable : !cpu.write;

	// 1 kB CHR slices
	assign chr_sel = bank.chr[chr_ain[12:10]];
	assign chr_addr = {4'b1000, chr_sel, chr_ain[9:0]};
	assign vram_ce = chr_ain[13]; // Nametables live in console VRAM

	always_comb begin
		case (bank.mirroring)
			fme7_pkg::MIRROR_VERTICAL: vram_a10 = chr_ain[10];
			fme7_pkg::MIRROR_HORIZONTAL: vram_a10 = chr_ain[11];
			fme7_pkg::MIRROR_ONE_LOW: vram_a10 = 1'b0;
			default: vram_a10 = 1'b1;  // One screen, upper page
		endcase
	end

endmodule

/* hw/fme7_irq.sv */
// FME-7 cycle counter IRQ
module fme7_irq (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cpu_ce,
	input  fme7_pkg::irq_wr_t irq_wr,
	output logic              irq
);

	logic             countdown;    // Counter runs
	logic             trigger;      // Underflow raises irq
	logic [15:0]      counter;
	logic [16:0]      counter_next; // Bit 16 is the borrow
	fme7_pkg::param_u ctrl;

	assign ctrl = irq_wr.data;
	assign counter_next = {1'b0, counter} - {16'b0, countdown};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			countdown <= 1'b0;
			trigger <= 1'b0;
			counter <= '0;
			irq <= 1'b0;
		end else if (cpu_ce) begin
			counter <= counter_next[15:0];

			// A load replaces only its own byte
			if (irq_wr.load_lo) begin
				counter[7:0] <= irq_wr.data;
			end
			if (irq_wr.load_hi) begin
				counter[15:8] <= irq_wr.data;
			end
			if (irq_wr.load_ctrl) begin
				countdown <= ctrl.irq_ctrl.countdown;
				trigger <= ctrl.irq_ctrl.trigger;
			end

			if (trigger && counter_next[16]) begin
				irq <= 1'b1;           // Wrap from 0 to FFFF
			end
			if (!trigger) begin
				irq <= 1'b0;           // Acknowledge
			end
		end
	end

endmodule

/* hw/fme7_regs.sv */
// FME-7 register file
module fme7_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cpu_ce,
	input  cpu_bus_pkg::cpu_bus_t cpu,
	output fme7_pkg::bank_state_t bank,
	output fme7_pkg::irq_wr_t     irq_wr
);

	logic [3:0]       cmd;      // Latched command number
	logic             reg_wr;
	logic             cmd_wr;
	logic             param_wr;
	fme7_pkg::param_u param;

	// Writes land only on a CPU cycle strobe
	assign reg_wr = cpu_ce & cpu.write & cpu.addr[cpu_bus_pkg::REG_WINDOW_BIT];
	assign cmd_wr = reg_wr && (cpu.addr[14:13] == cpu_bus_pkg::CMD_SEL);
	assign param_wr = reg_wr && (cpu.addr[14:13] == cpu_bus_pkg::PARAM_SEL);
	assign param = cpu.data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd <= '0;
			bank <= '0;
		end else if (cmd_wr) begin
			cmd <= cpu.data[3:0];
		end else if (param_wr) begin
			if (cmd < fme7_pkg::CMD_PRG_FIRST) begin
				bank.chr[cmd[2:0]] <= param.chr;
			end else if (cmd < fme7_pkg::CMD_MIRROR) begin
				bank.prg[cmd[1:0]] <= param.prg.bank;
			end else if (cmd == fme7_pkg::CMD_MIRROR) begin
				bank.mirroring <= fme7_pkg::mirror_t'(param.chr[1:0]);
			end

			// The $6000 window also carries the RAM controls
			if (cmd == fme7_pkg::CMD_PRG_FIRST) begin
				bank.ram_enable <= param.prg.ram_enable;
				bank.ram_select <= param.prg.ram_select;
			end
		end
	end

	// IRQ commands pass straight through as one-cycle strobes
	always_comb begin
		irq_wr = '0;
		irq_wr.data = cpu.data;
		if (param_wr) begin
			irq_wr.load_ctrl = (cmd == fme7_pkg::CMD_IRQ_CTRL);
			irq_wr.load_lo = (cmd == fme7_pkg::CMD_IRQ_LO);
			irq_wr.load_hi = (cmd == fme7_pkg::CMD_IRQ_HI);
		end
	end

endmodule

/* hw/fme7_pkg.sv */
// FME-7 mapper definitions
package fme7_pkg;

	// Command numbers written to $8000
	localparam logic [3:0] CMD_CHR_FIRST = 4'd0;
	localparam logic [3:0] CMD_PRG_FIRST = 4'd8;
	localparam logic [3:0] CMD_MIRROR = 4'd12;
	localparam logic [3:0] CMD_IRQ_CTRL = 4'd13;
	localparam logic [3:0] CMD_IRQ_LO = 4'd14;
	localparam logic [3:0] CMD_IRQ_HI = 4'd15;

	localparam int CHR_BANKS = 8;   // 1 kB each
	localparam int PRG_WINDOWS = 4; // 8 kB each, $6000-$DFFF

	typedef logic [4:0] prg_bank_t;
	typedef logic [7:0] chr_bank_t;

	typedef enum logic [1:0] {
		MIRROR_VERTICAL,
		MIRROR_HORIZONTAL,
		MIRROR_ONE_LOW,
		MIRROR_ONE_HIGH
	} mirror_t;

	typedef struct packed {
		logic      ram_enable;
		logic      ram_select; // RAM instead of ROM at $6000
		logic      spare;
		prg_bank_t bank;
	} prg_param_t;

	typedef struct packed {
		logic       countdown;
		logic [5:0] spare;
		logic       trigger;
	} irq_ctrl_param_t;

	// Parameter byte, meaning set by the latched command
	typedef union packed {
		chr_bank_t       chr;
		prg_param_t      prg;
		irq_ctrl_param_t irq_ctrl;
	} param_u;

	typedef struct packed {
		chr_bank_t [CHR_BANKS-1:0]   chr;
		prg_bank_t [PRG_WINDOWS-1:0] prg;
		logic                        ram_enable;
		logic                        ram_select;
		mirror_t                     mirroring;
	} bank_state_t;

	typedef struct packed {
		logic       load_lo;
		logic       load_hi;
		logic       load_ctrl;
		logic [7:0] data;
	} irq_wr_t;

endpackage

/* hw/cpu_bus_pkg.sv */
// Console bus definitions
package cpu_bus_pkg;

	// Translated memory address widths
	localparam int PRG_ADDR_W = 22;
	localparam int CHR_ADDR_W = 22;

	// Register window decode
	localparam int REG_WINDOW_BIT = 15;      // $8000 and up
	localparam logic [1:0] CMD_SEL = 2'd0;   // $8000-$9FFF
	localparam logic [1:0] PARAM_SEL = 2'd1; // $A000-$BFFF

	// One CPU access as seen by the cartridge
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        write;
		logic        read;
	} cpu_bus_t;

	// PPU address into cartridge space
	typedef logic [13:0] chr_bus_t;

endpackage
